/* sdram_defs.svh */
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// timing in controller clocks, sized for 66.7 MHz max (15 ns period)
`define SDRAM_T_RP    4'd1   // precharge to activate
`define SDRAM_T_RCD   4'd1   // activate to read/write
`define SDRAM_T_RC    4'd4   // refresh/activate to refresh/activate
`define SDRAM_T_WR    4'd2   // write recovery
`define SDRAM_T_MRD   4'd2   // mode register set to next command
`define SDRAM_CAS     4'd2   // cas latency, also loaded into mode register

// power-up wait before config
// short for simulation, about 10800 for 200 us on a 54 MHz board clock
`define SDRAM_INIT_W      15
`define SDRAM_INIT_WAIT   15'd200

// max cycles between refresh requests
// 4096 refreshes per 64 ms -> one per ~15 us, 750 at 54 MHz leaves margin
`define SDRAM_REFRESH_W         10
`define SDRAM_REFRESH_INTERVAL  10'd750

// geometry of the 64 Mbit x32 part: 2K rows, 256 cols, 4 banks
`define SDRAM_ADDR_W   23    // byte address
`define SDRAM_ROW_W    11    // also width of the a pins
`define SDRAM_COL_W    8
`define SDRAM_BANK_W   2
`define SDRAM_DATA_W   32
`define SDRAM_MASK_W   4     // one bit per byte lane

`endif

/* sdram_pkg.sv */
package sdram_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        st_init    = 3'd0,   // power-up wait
        st_config  = 3'd1,   // precharge all, 2x refresh, mode reg
        st_idle    = 3'd2,
        st_read    = 3'd3,
        st_write   = 3'd4,
        st_refresh = 3'd5
    } seq_state_e;

    // pin level commands as {ras_n, cas_n, we_n}
    // cs_n is tied low outside the controller
    typedef enum logic [2:0] {
        cmd_mode_reg     = 3'b000,
        cmd_auto_refresh = 3'b001,
        cmd_precharge    = 3'b010,
        cmd_activate     = 3'b011,
        cmd_write        = 3'b100,
        cmd_read         = 3'b101,
        cmd_nop          = 3'b111
    } sdram_cmd_e;

    // operation passed from decode to the sequencer
    typedef enum logic [1:0] {
        op_read    = 2'd0,
        op_write   = 2'd1,
        op_refresh = 2'd2    // generated internally, never by the host
    } seq_op_e;

endpackage

/* sdram_req_decode.sv */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_req_decode (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        req_valid,
    input  logic                        req_write,
    input  logic [`SDRAM_ADDR_W-1:0]    req_addr,    // byte address
    input  logic [`SDRAM_DATA_W-1:0]    req_wdata,
    input  logic [`SDRAM_MASK_W-1:0]    req_mask,    // byte enables, 1 = write lane
    input  logic                        op_ready,
    input  logic                        buf_free,
    input  logic                        init_done,
    output logic                        req_ready,
    output logic                        op_valid,
    output sdram_pkg::seq_op_e          op_kind,
    output logic [`SDRAM_BANK_W-1:0]    op_bank,
    output logic [`SDRAM_ROW_W-1:0]     op_row,
    output logic [`SDRAM_COL_W-1:0]     op_col,
    output logic [`SDRAM_DATA_W-1:0]    op_wdata,
    output logic [`SDRAM_MASK_W-1:0]    op_dqm
);
    import sdram_pkg::*;

    localparam int COL_LO  = 2;                      // word aligned, bits 1:0 dropped
    localparam int ROW_LO  = COL_LO + `SDRAM_COL_W;
    localparam int BANK_LO = ROW_LO + `SDRAM_ROW_W;

    logic                       ent_valid;   // one-entry request holding register
    logic                       ent_write;
    logic [`SDRAM_ADDR_W-1:0]   ent_addr;
    logic [`SDRAM_DATA_W-1:0]   ent_wdata;
    logic [`SDRAM_MASK_W-1:0]   ent_mask;

    logic [`SDRAM_REFRESH_W-1:0] ref_cnt;
    logic                        refresh_pending;

    logic req_fire;
    logic op_fire;

    assign req_ready = init_done && !ent_valid;   // nothing taken before config ends
    assign req_fire  = req_valid && req_ready;
    assign op_fire   = op_valid && op_ready;

    // refresh beats a waiting access
    // reads wait for a free return buffer, writes never do
    assign op_valid = refresh_pending || (ent_valid && (ent_write || buf_free));
    assign op_kind  = refresh_pending ? op_refresh : (ent_write ? op_write : op_read);

    // address split: | bank | row | col | byte |
    assign op_col   = ent_addr[ROW_LO-1:COL_LO];
    assign op_row   = ent_addr[BANK_LO-1:ROW_LO];
    assign op_bank  = ent_addr[BANK_LO+`SDRAM_BANK_W-1:BANK_LO];
    assign op_wdata = ent_wdata;
    assign op_dqm   = ent_write ? ~ent_mask : '0;   // dqm high masks a lane

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ent_valid <= 1'b0;
        end else if (req_fire) begin
            ent_valid <= 1'b1;
        end else if (op_fire && !refresh_pending) begin
            ent_valid <= 1'b0;   // access handed to sequencer
        end
    end

    // request payload, only meaningful while ent_valid
    always_ff @(posedge clk) begin
        if (req_fire) begin
            ent_write <= req_write;
            ent_addr  <= req_addr;
            ent_wdata <= req_wdata;
            ent_mask  <= req_mask;
        end
    end

    // free-running interval counter, keeps going while a refresh waits
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ref_cnt         <= '0;
            refresh_pending <= 1'b0;
        end else if (init_done) begin
            if (ref_cnt == `SDRAM_REFRESH_INTERVAL - 1'b1) begin
                ref_cnt         <= '0;
                refresh_pending <= 1'b1;   // single bit, so at most one queued
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
                if (op_fire && refresh_pending)
                    refresh_pending <= 1'b0;
            end
        end
    end

    // a read must never be offered with the return buffer occupied
    a_read_needs_buf: assert property (@(posedge clk) disable iff (!resetn)
        (op_valid && op_kind == op_read) |-> buf_free)
        else $error("read offered while return buffer busy");

endmodule

/* sdram_cmd_seq.sv */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_cmd_seq (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        op_valid,
    input  sdram_pkg::seq_op_e          op_kind,
    input  logic [`SDRAM_BANK_W-1:0]    op_bank,
    input  logic [`SDRAM_ROW_W-1:0]     op_row,
    input  logic [`SDRAM_COL_W-1:0]     op_col,
    input  logic [`SDRAM_DATA_W-1:0]    op_wdata,
    input  logic [`SDRAM_MASK_W-1:0]    op_dqm,
    output logic                        op_ready,
    output logic                        init_done,
    output logic                        rd_capture,   // dq_in holds read data this cycle
    output sdram_pkg::sdram_cmd_e       sdram_cmd,
    output logic [`SDRAM_BANK_W-1:0]    sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]     sdram_a,
    output logic [`SDRAM_MASK_W-1:0]    sdram_dqm,
    output logic [`SDRAM_DATA_W-1:0]    dq_out,
    output logic                        dq_oe
);
    import sdram_pkg::*;

    localparam logic [3:0] T_RP  = `SDRAM_T_RP;
    localparam logic [3:0] T_RCD = `SDRAM_T_RCD;
    localparam logic [3:0] T_RC  = `SDRAM_T_RC;
    localparam logic [3:0] T_WR  = `SDRAM_T_WR;
    localparam logic [3:0] T_MRD = `SDRAM_T_MRD;
    localparam logic [3:0] CAS   = `SDRAM_CAS;

    // config slots
    // cnt  0: precharge all, T_RP: refresh, +T_RC: refresh, +T_RC: mode reg, +T_MRD: idle
    localparam logic [3:0] CFG_REF1 = T_RP;
    localparam logic [3:0] CFG_REF2 = T_RP + T_RC;
    localparam logic [3:0] CFG_MRS  = T_RP + T_RC + T_RC;
    localparam logic [3:0] CFG_END  = CFG_MRS + T_MRD;

    // access slots, counted from the activate
    localparam logic [3:0] RD_CAP = T_RCD + CAS;        // data on dq next cycle
    localparam logic [3:0] RD_END = RD_CAP + 4'd1;
    localparam logic [3:0] WR_OFF = T_RCD + 4'd1;       // dq driven for one cycle only
    localparam logic [3:0] WR_END = T_RCD + T_WR + T_RP;

    // burst length 1, sequential, cas in 6:4
    localparam logic [`SDRAM_ROW_W-1:0] MODE_VAL = {4'b0000, CAS[2:0], 1'b0, 3'b000};
    localparam logic [`SDRAM_ROW_W-1:0] PRE_ALL  = 1 << 10;   // a10 selects all banks

    seq_state_e state;
    logic [3:0] cnt;                        // saturating slot counter

    logic [`SDRAM_INIT_W-1:0] wait_cnt;
    logic wait_done;
    logic wait_done_d;
    logic cfg_start;                        // one pulse after power-up wait

    logic [`SDRAM_COL_W-1:0]  col_q;        // column held until read/write slot
    logic [`SDRAM_ROW_W-1:0]  col_addr;
    logic accept;
    logic col_slot;

    assign op_ready = (state == st_idle);
    assign accept   = op_ready && op_valid;
    assign col_slot = (state == st_read || state == st_write) && cnt == T_RCD;
    // a10 high -> auto-precharge after the access
    assign col_addr = {1'b1, {(`SDRAM_ROW_W-1-`SDRAM_COL_W){1'b0}}, col_q};

    // power-up wait with edge detect to kick off config
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wait_cnt    <= '0;
            wait_done   <= 1'b0;
            wait_done_d <= 1'b0;
            cfg_start   <= 1'b0;
        end else begin
            wait_done_d <= wait_done;
            cfg_start   <= wait_done && !wait_done_d;
            if (wait_cnt == `SDRAM_INIT_WAIT)
                wait_done <= 1'b1;
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= st_init;
            cnt        <= '0;
            init_done  <= 1'b0;
            sdram_cmd  <= cmd_nop;
            sdram_dqm  <= '0;
            dq_oe      <= 1'b0;
            rd_capture <= 1'b0;
        end else begin
            sdram_cmd  <= cmd_nop;   // default every cycle
            rd_capture <= 1'b0;
            cnt        <= (cnt == 4'hf) ? cnt : cnt + 4'd1;
            case (state)
                st_init: begin
                    if (cfg_start) begin
                        state <= st_config;
                        cnt   <= '0;
                    end
                end
                st_config: begin
                    if (cnt == 4'd0) begin
                        sdram_cmd <= cmd_precharge;
                    end else if (cnt == CFG_REF1 || cnt == CFG_REF2) begin
                        sdram_cmd <= cmd_auto_refresh;
                    end else if (cnt == CFG_MRS) begin
                        sdram_cmd <= cmd_mode_reg;
                    end else if (cnt == CFG_END) begin
                        state     <= st_idle;
                        init_done <= 1'b1;   // stays set from here on
                    end
                end
                st_idle: begin
                    if (op_valid) begin
                        cnt <= 4'd1;
                        if (op_kind == op_refresh) begin
                            sdram_cmd <= cmd_auto_refresh;   // banks already closed
                            state     <= st_refresh;
                        end else begin
                            sdram_cmd <= cmd_activate;
                            sdram_dqm <= op_dqm;   // zero for reads
                            state     <= (op_kind == op_write) ? st_write : st_read;
                        end
                    end
                end
                st_read: begin
                    if (cnt == T_RCD) begin
                        sdram_cmd <= cmd_read;
                    end else if (cnt == RD_CAP) begin
                        rd_capture <= 1'b1;
                    end else if (cnt == RD_END) begin
                        state <= st_idle;
                    end
                end
                st_write: begin
                    if (cnt == T_RCD) begin
                        sdram_cmd <= cmd_write;
                        dq_oe     <= 1'b1;
                    end else if (cnt == WR_OFF) begin
                        dq_oe <= 1'b0;
                    end else if (cnt == WR_END) begin
                        state <= st_idle;   // write recovery + precharge done
                    end
                end
                st_refresh: begin
                    if (cnt == T_RC)
                        state <= st_idle;
                end
                default: state <= st_init;
            endcase
        end
    end

    // address, bank and write data, no reset needed
    always_ff @(posedge clk) begin
        if (accept) begin
            sdram_ba <= op_bank;
            sdram_a  <= op_row;    // row goes out with activate
            col_q    <= op_col;
            dq_out   <= op_wdata;
        end
        if (state == st_config && cnt == 4'd0)
            sdram_a <= PRE_ALL;
        if (state == st_config && cnt == CFG_MRS) begin
            sdram_a  <= MODE_VAL;
            sdram_ba <= '0;
        end
        if (col_slot)
            sdram_a <= col_addr;
    end

    // each write command carries data for exactly one cycle
    a_dq_oe_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        (sdram_cmd == cmd_write) |-> dq_oe ##1 !dq_oe)
        else $error("dq_oe not a single cycle around write");

    // nothing may follow a refresh until T_RC has run out
    a_refresh_quiet: assert property (@(posedge clk) disable iff (!resetn)
        (sdram_cmd == cmd_auto_refresh) |=> (sdram_cmd == cmd_nop) [*(`SDRAM_T_RC - 1)])
        else $error("command issued inside refresh T_RC window");

endmodule

/* sdram_read_return.sv */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_read_return (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        rd_capture,   // dq_in valid this cycle
    input  logic [`SDRAM_DATA_W-1:0]    dq_in,
    input  logic                        rsp_ready,
    output logic                        rsp_valid,
    output logic [`SDRAM_DATA_W-1:0]    rsp_data,
    output logic                        buf_free
);

    // busy from the capture cycle until the host takes the word
    assign buf_free = !(rsp_valid || rd_capture);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rsp_valid <= 1'b0;
        end else if (rd_capture) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;   // handshake done, or nothing held
        end
    end

    // sample dq on the capture pulse
    // data then sits still until accepted
    always_ff @(posedge clk) begin
        if (rd_capture)
            rsp_data <= dq_in;
    end

    // decode holds reads back while a word is unconsumed
    a_no_overwrite: assert property (@(posedge clk) disable iff (!resetn)
        rd_capture |-> !(rsp_valid && !rsp_ready))
        else $error("read data captured over an unaccepted response");

endmodule

/* sdram_ctrl_top.sv */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_ctrl_top (
    input  logic                        clk,
    input  logic                        resetn,
    // host request channel
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_write,
    input  logic [`SDRAM_ADDR_W-1:0]    req_addr,
    input  logic [`SDRAM_DATA_W-1:0]    req_wdata,
    input  logic [`SDRAM_MASK_W-1:0]    req_mask,
    // read response channel
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [`SDRAM_DATA_W-1:0]    rsp_data,
    // sdram pins, dq split into out/oe/in
    output sdram_pkg::sdram_cmd_e       sdram_cmd,
    output logic [`SDRAM_BANK_W-1:0]    sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]     sdram_a,
    output logic [`SDRAM_MASK_W-1:0]    sdram_dqm,
    output logic [`SDRAM_DATA_W-1:0]    dq_out,
    output logic                        dq_oe,
    input  logic [`SDRAM_DATA_W-1:0]    dq_in
);
    import sdram_pkg::*;

    logic                       op_valid;
    logic                       op_ready;
    seq_op_e                    op_kind;
    logic [`SDRAM_BANK_W-1:0]   op_bank;
    logic [`SDRAM_ROW_W-1:0]    op_row;
    logic [`SDRAM_COL_W-1:0]    op_col;
    logic [`SDRAM_DATA_W-1:0]   op_wdata;
    logic [`SDRAM_MASK_W-1:0]   op_dqm;
    logic                       init_done;
    logic                       rd_capture;
    logic                       buf_free;

    sdram_req_decode u_decode (
        .clk       (clk),
        .resetn    (resetn),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_mask  (req_mask),
        .op_ready  (op_ready),
        .buf_free  (buf_free),
        .init_done (init_done),
        .req_ready (req_ready),
        .op_valid  (op_valid),
        .op_kind   (op_kind),
        .op_bank   (op_bank),
        .op_row    (op_row),
        .op_col    (op_col),
        .op_wdata  (op_wdata),
        .op_dqm    (op_dqm)
    );

    sdram_cmd_seq u_seq (
        .clk        (clk),
        .resetn     (resetn),
        .op_valid   (op_valid),
        .op_kind    (op_kind),
        .op_bank    (op_bank),
        .op_row     (op_row),
        .op_col     (op_col),
        .op_wdata   (op_wdata),
        .op_dqm     (op_dqm),
        .op_ready   (op_ready),
        .init_done  (init_done),
        .rd_capture (rd_capture),
        .sdram_cmd  (sdram_cmd),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .sdram_dqm  (sdram_dqm),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe)
    );

    sdram_read_return u_result (
        .clk        (clk),
        .resetn     (resetn),
        .rd_capture (rd_capture),
        .dq_in      (dq_in),
        .rsp_ready  (rsp_ready),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .buf_free   (buf_free)
    );

endmodule

/* sdram_model.sv */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_model (
    input  logic                        clk,
    input  sdram_pkg::sdram_cmd_e       sdram_cmd,
    input  logic [`SDRAM_BANK_W-1:0]    sdram_ba,
    input  logic [`SDRAM_ROW_W-1:0]     sdram_a,
    input  logic [`SDRAM_MASK_W-1:0]    sdram_dqm,
    input  logic [`SDRAM_DATA_W-1:0]    dq_out,
    input  logic                        dq_oe,
    output logic [`SDRAM_DATA_W-1:0]    dq_in,
    output logic                        fault      // sticky, any timing or protocol violation
);
    import sdram_pkg::*;

    // interval plus the longest access and the config tail before counting starts
    localparam int REF_LIMIT = `SDRAM_REFRESH_INTERVAL + 12;

    logic [`SDRAM_DATA_W-1:0] mem [int unsigned];    // keyed by {bank, row, col}
    logic [`SDRAM_ROW_W-1:0]  open_row [4];          // row latched by each activate
    logic [`SDRAM_DATA_W-1:0] rd_word;
    logic [3:0]               rd_cnt;                // cycles left until dq_in drive
    int unsigned              since_ras;
    int unsigned              since_ref;
    logic                     running;               // mode reg seen

    // untouched words read back as a pattern of their own address
    function automatic logic [31:0] fill_word(input logic [20:0] waddr);
        return {3'b101, waddr, 8'h3c};
    endfunction

    task automatic flag(input string why);
        if (!fault)
            $display("sdram model: %s at %0t", why, $time);
        fault <= 1'b1;
    endtask

    initial begin
        dq_in     = '0;
        fault     = 1'b0;
        rd_cnt    = '0;
        since_ras = 0;
        since_ref = 0;
        running   = 1'b0;
    end

    always @(posedge clk) begin : cmd_decode
        logic [20:0] waddr;
        logic [31:0] word;
        since_ras <= since_ras + 1;
        since_ref <= since_ref + 1;
        dq_in     <= 32'hbad0_0bad;   // garbage outside the data cycle
        if (rd_cnt != 0) begin
            rd_cnt <= rd_cnt - 4'd1;
            if (rd_cnt == 4'd1)
                dq_in <= rd_word;   // valid for the capture edge
        end
        waddr = {sdram_ba, open_row[sdram_ba], sdram_a[`SDRAM_COL_W-1:0]};
        case (sdram_cmd)
            cmd_activate: begin
                if (since_ras + 1 < `SDRAM_T_RC)
                    flag("activate issued less than T_RC after refresh or activate");
                open_row[sdram_ba] <= sdram_a;
                since_ras          <= 0;
            end
            cmd_auto_refresh: begin
                since_ras <= 0;
                since_ref <= 0;
            end
            cmd_mode_reg: running <= 1'b1;
            cmd_read: begin
                rd_word <= mem.exists(waddr) ? mem[waddr] : fill_word(waddr);
                rd_cnt  <= `SDRAM_CAS - 4'd1;
            end
            cmd_write: begin
                if (!dq_oe)
                    flag("write command without driven data");
                word = mem.exists(waddr) ? mem[waddr] : fill_word(waddr);
                for (int i = 0; i < 4; i++)
                    if (!sdram_dqm[i])
                        word[8*i +: 8] = dq_out[8*i +: 8];   // dqm low lets lane through
                mem[waddr] = word;
            end
            default: ;
        endcase
        if (running && since_ref > REF_LIMIT)
            flag("refresh interval exceeded");
    end

endmodule

/* tb_sdram_ctrl.sv */
`timescale 1ns/1ps
`include "sdram_defs.svh"

module tb_sdram_ctrl;
    import sdram_pkg::*;

    localparam int WAIT_LIMIT = 100;                     // cycles per handshake or command
    localparam int INIT_LIMIT = `SDRAM_INIT_WAIT + 100;
    localparam logic [`SDRAM_ROW_W-1:0] MRS_EXP = `SDRAM_ROW_W'(`SDRAM_CAS) << 4;

    logic                        clk;
    logic                        resetn;
    logic                        req_valid;
    logic                        req_ready;
    logic                        req_write;
    logic [`SDRAM_ADDR_W-1:0]    req_addr;
    logic [`SDRAM_DATA_W-1:0]    req_wdata;
    logic [`SDRAM_MASK_W-1:0]    req_mask;
    logic                        rsp_valid;
    logic                        rsp_ready;
    logic [`SDRAM_DATA_W-1:0]    rsp_data;
    sdram_cmd_e                  sdram_cmd;
    logic [`SDRAM_BANK_W-1:0]    sdram_ba;
    logic [`SDRAM_ROW_W-1:0]     sdram_a;
    logic [`SDRAM_MASK_W-1:0]    sdram_dqm;
    logic [`SDRAM_DATA_W-1:0]    dq_out;
    logic                        dq_oe;
    logic [`SDRAM_DATA_W-1:0]    dq_in;
    logic                        model_fault;

    logic [`SDRAM_DATA_W-1:0] ref_mem [int unsigned];   // expected contents by word address
    logic [31:0]              lcg_state;

    sdram_ctrl_top uut (
        .clk       (clk),
        .resetn    (resetn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_mask  (req_mask),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .sdram_cmd (sdram_cmd),
        .sdram_ba  (sdram_ba),
        .sdram_a   (sdram_a),
        .sdram_dqm (sdram_dqm),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in)
    );

    sdram_model mem_model (
        .clk       (clk),
        .sdram_cmd (sdram_cmd),
        .sdram_ba  (sdram_ba),
        .sdram_a   (sdram_a),
        .sdram_dqm (sdram_dqm),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in),
        .fault     (model_fault)
    );

    always #20 clk = ~clk;   // 40 ns period

    task automatic abort_run(input string why);
        if (why != "")
            $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        if (model_fault)
            abort_run("SDRAM model reported a timing or protocol violation");
    end

    task automatic check_cmd(input string name, input sdram_cmd_e got, input sdram_cmd_e exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%s exp=%s", $time, name, got.name(), exp.name());
            abort_run("");
        end
    endtask

    task automatic check_word(input string name, input logic [`SDRAM_DATA_W-1:0] got,
                              input logic [`SDRAM_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort_run("");
        end
    endtask

    task automatic check_bits(input string name, input logic [`SDRAM_ROW_W-1:0] got,
                              input logic [`SDRAM_ROW_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort_run("");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // same address pattern the model returns for unwritten words
    function automatic logic [31:0] fill_word(input logic [20:0] waddr);
        return {3'b101, waddr, 8'h3c};
    endfunction

    function automatic logic [31:0] ref_read(input logic [`SDRAM_ADDR_W-1:0] addr);
        return ref_mem.exists(addr[22:2]) ? ref_mem[addr[22:2]] : fill_word(addr[22:2]);
    endfunction

    task automatic ref_write(input logic [`SDRAM_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        logic [31:0] w;
        w = ref_read(addr);
        for (int i = 0; i < 4; i++)
            if (mask[i])
                w[8*i +: 8] = data[8*i +: 8];   // enabled lanes only
        ref_mem[addr[22:2]] = w;
    endtask

    // drives on a rising edge, samples outputs at the falling edge
    task automatic send_req(input logic wr, input logic [`SDRAM_ADDR_W-1:0] addr,
                            input logic [31:0] data, input logic [3:0] mask);
        int n;
        logic rdy;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= data;
        req_mask  <= mask;
        do begin
            @(negedge clk);
            rdy = req_ready;
            @(posedge clk);   // transfer edge when rdy was high
            n++;
            if (n > WAIT_LIMIT)
                abort_run("request was never accepted");
        end while (!rdy);
        req_valid <= 1'b0;
    endtask

    task automatic wait_cmd(input sdram_cmd_e cmd);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                abort_run($sformatf("no %s command on the pins", cmd.name()));
        end while (sdram_cmd != cmd);
    endtask

    task automatic wait_rsp(output logic [31:0] data);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                abort_run("read response never arrived");
        end while (!rsp_valid);
        data = rsp_data;
    endtask

    // activate must carry bank and row of the byte address
    task automatic check_activate(input logic [`SDRAM_ADDR_W-1:0] addr);
        wait_cmd(cmd_activate);
        check_bits("sdram_ba", sdram_ba, addr[22:21]);
        check_bits("sdram_a row", sdram_a, addr[20:10]);
    endtask

    task automatic do_write(input logic [`SDRAM_ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
        send_req(1'b1, addr, data, mask);
        check_activate(addr);
        wait_cmd(cmd_write);
        check_bits("sdram_a col", sdram_a, (11'd1 << 10) | addr[9:2]);   // a10 = auto-precharge
        check_bits("sdram_dqm", sdram_dqm, 4'(~mask));
        check_bits("dq_oe", dq_oe, 1'b1);
        check_word("dq_out", dq_out, data);
        ref_write(addr, data, mask);
    endtask

    task automatic do_read(input logic [`SDRAM_ADDR_W-1:0] addr);
        logic [31:0] got;
        send_req(1'b0, addr, '0, '0);
        check_activate(addr);
        wait_cmd(cmd_read);
        check_bits("sdram_a col", sdram_a, (11'd1 << 10) | addr[9:2]);
        wait_rsp(got);
        check_word("rsp_data", got, ref_read(addr));
    endtask

    task automatic test_init();
        sdram_cmd_e exp_seq [4];
        int seen;
        int n;
        exp_seq = '{cmd_precharge, cmd_auto_refresh, cmd_auto_refresh, cmd_mode_reg};
        seen = 0;
        n = 0;
        @(negedge clk);   // first cycle out of reset
        check_bits("rsp_valid", rsp_valid, 1'b0);
        check_bits("dq_oe", dq_oe, 1'b0);
        check_bits("sdram_dqm", sdram_dqm, '0);
        check_cmd("sdram_cmd", sdram_cmd, cmd_nop);
        while (seen < 4) begin
            @(negedge clk);
            n++;
            if (n > INIT_LIMIT)
                abort_run("init command sequence did not complete");
            check_bits("req_ready", req_ready, 1'b0);   // closed until config is over
            if (sdram_cmd != cmd_nop) begin
                check_cmd("sdram_cmd", sdram_cmd, exp_seq[seen]);
                if (seen == 0)
                    check_bits("sdram_a[10]", sdram_a[10], 1'b1);
                if (seen == 3)
                    check_bits("sdram_a", sdram_a, MRS_EXP);
                seen++;
            end
        end
        n = 0;
        while (!req_ready) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                abort_run("req_ready never rose after init");
        end
    endtask

    task automatic test_write_read();
        do_write(23'h2a_5d4c, 32'hcafe_f00d, 4'hf);
        do_read(23'h2a_5d4c);
        do_write(23'h41_03f8, 32'h1234_5678, 4'hf);   // different bank, row and column
        do_read(23'h41_03f8);
    endtask

    task automatic test_byte_masks();
        logic [3:0] masks [5];
        masks = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
        do_write(23'h10_0100, 32'h0000_0000, 4'hf);
        foreach (masks[i]) begin
            do_write(23'h10_0100, lcg_next(), masks[i]);
            do_read(23'h10_0100);
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] held;
        logic [31:0] got;
        do_write(23'h02_0040, 32'ha5a5_0001, 4'hf);
        @(posedge clk);
        rsp_ready <= 1'b0;
        send_req(1'b0, 23'h02_0040, '0, '0);
        wait_rsp(held);
        check_word("rsp_data", held, ref_read(23'h02_0040));
        do_write(23'h02_0080, 32'h5a5a_0002, 4'hf);   // writes still go through
        send_req(1'b0, 23'h02_0080, '0, '0);
        repeat (20) begin
            @(negedge clk);
            check_bits("rsp_valid", rsp_valid, 1'b1);
            check_word("rsp_data", rsp_data, held);
            check_bits("req_ready", req_ready, 1'b0);   // second read parked in decode
            if (sdram_cmd == cmd_read)
                abort_run("second read issued while the response was held");
        end
        @(posedge clk);
        rsp_ready <= 1'b1;
        @(posedge clk);   // first response taken here
        wait_rsp(got);
        check_word("rsp_data", got, ref_read(23'h02_0080));
    endtask

    task automatic test_refresh();
        int since;
        int count;
        since = 0;
        count = 0;
        repeat (3 * `SDRAM_REFRESH_INTERVAL + 10) begin
            @(negedge clk);
            since++;
            if (sdram_cmd == cmd_auto_refresh) begin
                count++;
                since = 0;
            end
            if (since > `SDRAM_REFRESH_INTERVAL)
                abort_run("no auto refresh within one refresh interval");
        end
        if (count < 3)
            abort_run("fewer than three refreshes over three intervals");
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [`SDRAM_ADDR_W-1:0] addr;
        repeat (200) begin
            r = lcg_next();
            // window: 4 banks x 4 rows x 4 columns
            addr = {r[17:16], 9'd0, r[19:18], 6'd0, r[21:20], 2'b00};
            if (r[24])
                do_write(addr, lcg_next(), r[28:25]);
            else
                do_read(addr);
        end
    endtask

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_mask  = '0;
        rsp_ready = 1'b1;
        lcg_state = 32'd91;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        test_init();
        test_write_read();
        test_byte_masks();
        test_backpressure();
        test_refresh();
        test_random();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* sdram_ctrl.f */
+incdir+.
sdram_pkg.sv
sdram_req_decode.sv
sdram_cmd_seq.sv
sdram_read_return.sv
sdram_ctrl_top.sv
sdram_model.sv
tb_sdram_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sdram_ctrl.f --top-module tb_sdram_ctrl -o sim_sdram_ctrl

out=$(./obj_dir/sim_sdram_ctrl 2>&1 || true)
echo "$out"
if grep -q 'All tests passed!' <<< "$out"; then
    exit 0
fi
exit 1
